//--- list.f
uart_cfg_pkg.sv
uart_line_pkg.sv
uart_regfile.sv
uart_tx_fifo.sv
uart_tx.sv
uart_top.sv
uart_tx_assert.sv
tb_uart_top.sv

//--- run_sim.sh
#!/bin/bash
# builds the UART testbench with Verilator, runs it and checks the log
LOG=sim.log
FAIL_MSG="tests failed"
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert --top-module tb_uart_top -f list.f > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_uart_top >> "$LOG" 2>&1 \
    || echo "$FAIL_MSG: build or simulation exited with an error" >> "$LOG"
cat "$LOG"
grep -q "$FAIL_MSG" "$LOG" && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- tb_uart_top.sv
`timescale 1ns/100ps

module tb_uart_top
    import uart_cfg_pkg::*;
    import uart_line_pkg::*;
();

    localparam int ack_timeout  = 1000;     // cycles, longer than one full frame
    localparam int line_timeout = 2000;
    localparam int no_ack_wait  = 40;
    localparam int num_rows     = 6;
    localparam int burst_len    = fifo_depth + 2;

    typedef struct packed {
        logic    par_en;
        logic    par_type;
        logic    stop2;
        nibble_t flen;
        logic    rnd;       // take a random byte instead of value
        byte_t   value;
    } row_t;

    localparam row_t rows [num_rows] = '{
        '{1'b1, 1'b0, 1'b0, 4'd8, 1'b0, 8'ha5},
        '{1'b1, 1'b1, 1'b0, 4'd7, 1'b0, 8'h3c},
        '{1'b0, 1'b0, 1'b1, 4'd8, 1'b1, 8'h00},
        '{1'b1, 1'b1, 1'b1, 4'd5, 1'b1, 8'h00},
        '{1'b0, 1'b1, 1'b0, 4'd6, 1'b0, 8'hf0},
        '{1'b1, 1'b0, 1'b1, 4'd8, 1'b1, 8'h00}
    };

    logic    clk_16bd = 1'b0;
    logic    rst;
    logic    valid;
    nibble_t address;
    nibble_t data;
    logic    ack;
    logic    data_out_valid;
    nibble_t data_out;
    logic    tx;
    logic    busy;

    always #4 clk_16bd = ~clk_16bd;

    uart_top u_dut (
        .clk_16bd       (clk_16bd),
        .rst            (rst),
        .valid          (valid),
        .address        (address),
        .data           (data),
        .ack            (ack),
        .data_out_valid (data_out_valid),
        .data_out       (data_out),
        .tx             (tx),
        .busy           (busy)
    );

    // ********************
    // result checks
    // ********************
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_nibble(input nibble_t got, input nibble_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0.1f ns: %s is %0d, expected %0d",
                               $realtime, what, got, exp));
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0.1f ns: %s are %h, expected %h",
                               $realtime, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0.1f ns: %s is %b, expected %b",
                               $realtime, what, got, exp));
        end
    endtask

    // ********************
    // host port
    // ********************
    task automatic host_access(input nibble_t addr, input nibble_t value, output nibble_t rdata,
                               output logic rvalid, output int waited);
        @(negedge clk_16bd);
        valid   = 1'b1;
        address = addr;
        data    = value;
        waited  = 0;
        @(negedge clk_16bd);
        while (!ack) begin
            waited++;
            if (waited > ack_timeout) begin
                fail_run($sformatf("no ack for address %0d within the timeout", addr));
            end
            @(negedge clk_16bd);
        end
        rdata  = data_out;     // strobes are only high during the ack cycle
        rvalid = data_out_valid;
        valid  = 1'b0;
    endtask

    task automatic write_reg(input nibble_t addr, input nibble_t value);
        nibble_t rdata;
        logic    rvalid;
        int      waited;
        host_access(addr, value, rdata, rvalid, waited);
        check_bit(rvalid, 1'b0, "data_out_valid on a write");
    endtask

    task automatic read_reg(input nibble_t addr, output nibble_t value);
        logic rvalid;
        int   waited;
        host_access(addr, read_code, value, rvalid, waited);
        check_bit(rvalid, 1'b1, "data_out_valid on a readback");
    endtask

    task automatic push_byte(input byte_t value, output int waited);
        nibble_t rdata;
        logic    rvalid;
        host_access(addr_tx_low, value[3:0], rdata, rvalid, waited);
        host_access(addr_tx_high, value[7:4], rdata, rvalid, waited);
    endtask

    task automatic check_config(input logic p, input logic pt, input logic sb, input nibble_t fl);
        nibble_t rd;
        read_reg(addr_parity, rd);
        check_nibble(rd, {3'b000, p}, "parity enable");
        read_reg(addr_parity_type, rd);
        check_nibble(rd, {3'b000, pt}, "parity type");
        read_reg(addr_stop_bits, rd);
        check_nibble(rd, {3'b000, sb}, "stop bits");
        read_reg(addr_frame_length, rd);
        check_nibble(rd, fl, "frame length");
    endtask

    task automatic no_ack_access(input nibble_t addr, input nibble_t value);
        @(negedge clk_16bd);
        valid   = 1'b1;
        address = addr;
        data    = value;
        for (int i = 0; i < no_ack_wait; i++) begin
            @(negedge clk_16bd);
            if (ack || data_out_valid) begin
                fail_run($sformatf("unknown address %0d was acknowledged", addr));
            end
        end
        valid = 1'b0;
    endtask

    // ********************
    // line decoder
    // ********************
    task automatic receive_frame(input logic par_en, input logic par_type, input logic stop2,
                                 input nibble_t flen, input byte_t expected);
        byte_t got;
        byte_t want;
        int    waited;
        got    = '0;
        want   = '0;
        waited = 0;
        for (int i = 0; i < 8; i++) begin
            if (i < int'(flen)) want[i] = expected[i];    // bits above frame_length are not sent
        end
        @(negedge clk_16bd);
        while (tx !== 1'b0) begin
            waited++;
            if (waited > line_timeout) begin
                fail_run("no start bit appeared on tx within the timeout");
            end
            @(negedge clk_16bd);
        end
        repeat (os_rate / 2) @(negedge clk_16bd);
        check_bit(tx, 1'b0, "start bit");
        check_bit(busy, 1'b1, "busy during a frame");
        for (int i = 0; i < int'(flen); i++) begin
            repeat (os_rate) @(negedge clk_16bd);
            got[i] = tx;
        end
        check_byte(got, want, "data bits");
        if (par_en) begin
            repeat (os_rate) @(negedge clk_16bd);
            check_bit(tx, (^want) ^ par_type, "parity bit");
        end
        repeat (os_rate) @(negedge clk_16bd);
        check_bit(tx, 1'b1, "first stop bit");
        if (stop2) begin
            repeat (os_rate) @(negedge clk_16bd);
            check_bit(tx, 1'b1, "second stop bit");
        end
    endtask

    initial begin
        row_t  row;
        byte_t value;
        byte_t burst [burst_len];
        int    waited;
        void'($urandom(32'h83b1));
        rst     = 1'b1;
        valid   = 1'b0;
        address = '0;
        data    = '0;
        repeat (4) @(posedge clk_16bd);
        @(negedge clk_16bd);
        rst = 1'b0;

        check_bit(tx, 1'b1, "tx after reset");
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(ack, 1'b0, "ack after reset");
        check_bit(data_out_valid, 1'b0, "data_out_valid after reset");
        check_nibble(data_out, 4'd0, "data_out after reset");
        check_config(1'b1, 1'b0, 1'b0, 4'd8);

        for (int r = 0; r < num_rows; r++) begin
            row = rows[r];
            write_reg(addr_parity, {3'b000, row.par_en});
            write_reg(addr_parity_type, {3'b000, row.par_type});
            write_reg(addr_stop_bits, {3'b000, row.stop2});
            write_reg(addr_frame_length, row.flen);
            write_reg(addr_frame_length, (r % 2 == 0) ? 4'd3 : 4'd9);   // must be dropped
            check_config(row.par_en, row.par_type, row.stop2, row.flen);
            value = row.rnd ? byte_t'($urandom()) : row.value;
            push_byte(value, waited);
            receive_frame(row.par_en, row.par_type, row.stop2, row.flen, value);
        end

        // back-pressure with one byte in the serializer and a full FIFO
        write_reg(addr_parity, 4'd1);
        write_reg(addr_parity_type, 4'd0);
        write_reg(addr_stop_bits, 4'd0);
        write_reg(addr_frame_length, 4'd8);
        for (int i = 0; i < burst_len; i++) begin
            burst[i] = byte_t'($urandom());
        end
        fork
            begin
                for (int i = 0; i < burst_len; i++) begin
                    push_byte(burst[i], waited);
                    if (i == burst_len - 1 && waited < os_rate) begin
                        fail_run("a push into the full FIFO was acknowledged without a stall");
                    end
                end
            end
            begin
                for (int i = 0; i < burst_len; i++) begin
                    receive_frame(1'b1, 1'b0, 1'b0, 4'd8, burst[i]);
                end
            end
        join

        no_ack_access(4'd0, 4'd5);
        no_ack_access(4'd7, 4'd1);
        no_ack_access(4'd13, 4'd0);
        check_config(1'b1, 1'b0, 1'b0, 4'd8);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- uart_cfg_pkg.sv
package uart_cfg_pkg;

    // ********************
    // host bus
    // ********************
    typedef logic [3:0] nibble_t;   // address or data on the host port

    // data value that turns a configuration access into a readback
    localparam nibble_t read_code = 4'd15;

    // ********************
    // register map
    // ********************
    localparam nibble_t addr_tx_low       = 4'd1;   // low nibble of the next byte
    localparam nibble_t addr_tx_high      = 4'd2;   // high nibble, pushes the byte
    localparam nibble_t addr_parity       = 4'd9;
    localparam nibble_t addr_parity_type  = 4'd10;
    localparam nibble_t addr_stop_bits    = 4'd11;
    localparam nibble_t addr_frame_length = 4'd12;

    // ********************
    // line format
    // ********************
    localparam logic    rst_parity       = 1'b1;    // parity on after reset
    localparam logic    rst_parity_type  = 1'b0;    // even
    localparam logic    rst_stop_bits    = 1'b0;    // one stop bit
    localparam nibble_t rst_frame_length = 4'd8;

    // frame lengths outside this range are acked and dropped
    localparam nibble_t min_frame_length = 4'd5;
    localparam nibble_t max_frame_length = 4'd8;

endpackage

//--- uart_line_pkg.sv
package uart_line_pkg;

    typedef logic [7:0] byte_t;     // one transmit byte

    // ********************
    // transmit buffer
    // ********************
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    typedef logic [3:0]            fifo_count_t;    // holds 0 up to fifo_depth
    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;

    // ********************
    // serializer
    // ********************
    localparam int os_rate = 16;    // clock cycles per line bit

    typedef logic [3:0] os_count_t;
    typedef logic [3:0] bit_index_t;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } tx_state_t;

endpackage

//--- uart_regfile.sv
`timescale 1ns/100ps

module uart_regfile
    import uart_cfg_pkg::*;
    import uart_line_pkg::*;
(
    input  logic    clk_16bd,
    input  logic    rst,
    input  logic    valid,
    input  nibble_t address,
    input  nibble_t data,
    input  logic    full,
    output logic    ack,
    output logic    data_out_valid,
    output nibble_t data_out,
    output logic    parity,
    output logic    parity_type,
    output logic    stop_bits,
    output nibble_t frame_length,
    output logic    push,
    output byte_t   push_data
);

    logic    parity_ff, parity_nxt;
    logic    parity_type_ff, parity_type_nxt;
    logic    stop_bits_ff, stop_bits_nxt;
    nibble_t frame_length_ff, frame_length_nxt;
    logic    count_ff, count_nxt;
    logic    ack_ff, ack_nxt;
    logic    data_out_valid_ff, data_out_valid_nxt;
    nibble_t data_out_ff, data_out_nxt;
    logic    push_ff, push_nxt;
    byte_t   push_data_ff, push_data_nxt;
    nibble_t low_nibble_ff, low_nibble_nxt;
    logic    accept;

    assign parity         = parity_ff;
    assign parity_type    = parity_type_ff;
    assign stop_bits      = stop_bits_ff;
    assign frame_length   = frame_length_ff;
    assign ack            = ack_ff;
    assign data_out_valid = data_out_valid_ff;
    assign data_out       = data_out_ff;
    assign push           = push_ff;
    assign push_data      = push_data_ff;

    // ********************
    // request decode
    // ********************
    always_comb begin
        parity_nxt         = parity_ff;
        parity_type_nxt    = parity_type_ff;
        stop_bits_nxt      = stop_bits_ff;
        frame_length_nxt   = frame_length_ff;
        low_nibble_nxt     = low_nibble_ff;
        push_data_nxt      = push_data_ff;
        ack_nxt            = 1'b0;  // response strobes last a single cycle
        data_out_valid_nxt = 1'b0;
        data_out_nxt       = '0;
        push_nxt           = 1'b0;
        count_nxt          = 1'b0;
        accept             = 1'b0;

        if (valid && !count_ff) begin   // no request is taken in the recovery cycle
            case (address)
                addr_parity: begin
                    if (data == read_code) begin
                        data_out_nxt       = {3'b000, parity_ff};
                        data_out_valid_nxt = 1'b1;
                    end else begin
                        parity_nxt = data[0];
                    end
                    accept = 1'b1;
                end
                addr_parity_type: begin
                    if (data == read_code) begin
                        data_out_nxt       = {3'b000, parity_type_ff};
                        data_out_valid_nxt = 1'b1;
                    end else begin
                        parity_type_nxt = data[0];
                    end
                    accept = 1'b1;
                end
                addr_stop_bits: begin
                    if (data == read_code) begin
                        data_out_nxt       = {3'b000, stop_bits_ff};
                        data_out_valid_nxt = 1'b1;
                    end else begin
                        stop_bits_nxt = data[0];
                    end
                    accept = 1'b1;
                end
                addr_frame_length: begin
                    if (data == read_code) begin
                        data_out_nxt       = frame_length_ff;
                        data_out_valid_nxt = 1'b1;
                    end else if (data >= min_frame_length && data <= max_frame_length) begin
                        frame_length_nxt = data;
                    end
                    accept = 1'b1;          // out of range lengths are still acked
                end
                addr_tx_low: begin
                    low_nibble_nxt = data;  // every data value is payload here
                    accept         = 1'b1;
                end
                addr_tx_high: begin
                    if (!full) begin        // held off until the FIFO has room
                        push_nxt      = 1'b1;
                        push_data_nxt = {data, low_nibble_ff};
                        accept        = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end

        if (accept) begin
            ack_nxt   = 1'b1;
            count_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            parity_ff         <= rst_parity;
            parity_type_ff    <= rst_parity_type;
            stop_bits_ff      <= rst_stop_bits;
            frame_length_ff   <= rst_frame_length;
            count_ff          <= 1'b0;
            ack_ff            <= 1'b0;
            data_out_valid_ff <= 1'b0;
            data_out_ff       <= '0;
            push_ff           <= 1'b0;
        end else begin
            parity_ff         <= parity_nxt;
            parity_type_ff    <= parity_type_nxt;
            stop_bits_ff      <= stop_bits_nxt;
            frame_length_ff   <= frame_length_nxt;
            count_ff          <= count_nxt;
            ack_ff            <= ack_nxt;
            data_out_valid_ff <= data_out_valid_nxt;
            data_out_ff       <= data_out_nxt;
            push_ff           <= push_nxt;
        end
    end

    always_ff @(posedge clk_16bd) begin
        low_nibble_ff <= low_nibble_nxt;
        push_data_ff  <= push_data_nxt;
    end

endmodule

//--- uart_top.sv
`timescale 1ns/100ps

module uart_top
    import uart_cfg_pkg::*;
    import uart_line_pkg::*;
(
    input  logic    clk_16bd,
    input  logic    rst,
    input  logic    valid,
    input  nibble_t address,
    input  nibble_t data,
    output logic    ack,
    output logic    data_out_valid,
    output nibble_t data_out,
    output logic    tx,
    output logic    busy
);

    logic    parity;
    logic    parity_type;
    logic    stop_bits;
    nibble_t frame_length;    // line format, static between host writes
    logic    push;
    byte_t   push_data;
    logic    full;
    logic    pop;
    byte_t   pop_data;
    logic    empty;

    uart_regfile u_regfile (
        .clk_16bd       (clk_16bd),
        .rst            (rst),
        .valid          (valid),
        .address        (address),
        .data           (data),
        .full           (full),
        .ack            (ack),
        .data_out_valid (data_out_valid),
        .data_out       (data_out),
        .parity         (parity),
        .parity_type    (parity_type),
        .stop_bits      (stop_bits),
        .frame_length   (frame_length),
        .push           (push),
        .push_data      (push_data)
    );

    uart_tx_fifo u_fifo (
        .clk_16bd  (clk_16bd),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    uart_tx u_tx (
        .clk_16bd     (clk_16bd),
        .rst          (rst),
        .empty        (empty),
        .pop_data     (pop_data),
        .parity       (parity),
        .parity_type  (parity_type),
        .stop_bits    (stop_bits),
        .frame_length (frame_length),
        .pop          (pop),
        .tx           (tx),
        .busy         (busy)
    );

endmodule

//--- uart_tx.sv
`timescale 1ns/100ps

module uart_tx
    import uart_cfg_pkg::*;
    import uart_line_pkg::*;
(
    input  logic    clk_16bd,
    input  logic    rst,
    input  logic    empty,
    input  byte_t   pop_data,
    input  logic    parity,
    input  logic    parity_type,
    input  logic    stop_bits,
    input  nibble_t frame_length,
    output logic    pop,
    output logic    tx,
    output logic    busy
);

    tx_state_t  state, state_nxt;
    os_count_t  os_cnt, os_cnt_nxt;
    bit_index_t bit_idx, bit_idx_nxt;
    byte_t      shift_ff, shift_nxt;
    logic       parity_acc_ff, parity_acc_nxt;
    logic       stop_idx_ff, stop_idx_nxt;
    logic       par_en_ff, par_en_nxt;
    logic       par_type_ff, par_type_nxt;
    logic       stop2_ff, stop2_nxt;
    nibble_t    frame_len_ff, frame_len_nxt;
    logic       tx_ff, tx_nxt;
    logic       bit_done;

    assign pop      = (state == st_idle) && !empty;     // leaves st_idle at the next edge
    assign busy     = (state != st_idle);
    assign tx       = tx_ff;
    assign bit_done = (os_cnt == os_count_t'(os_rate - 1));

    // ********************
    // frame sequencing
    // ********************
    always_comb begin
        state_nxt      = state;
        os_cnt_nxt     = os_cnt + 1'b1;
        bit_idx_nxt    = bit_idx;
        shift_nxt      = shift_ff;
        parity_acc_nxt = parity_acc_ff;
        stop_idx_nxt   = stop_idx_ff;
        par_en_nxt     = par_en_ff;
        par_type_nxt   = par_type_ff;
        stop2_nxt      = stop2_ff;
        frame_len_nxt  = frame_len_ff;

        case (state)
            st_idle: begin
                os_cnt_nxt = '0;
                if (pop) begin  // byte and line format are frozen for the whole frame
                    shift_nxt      = pop_data;
                    par_en_nxt     = parity;
                    par_type_nxt   = parity_type;
                    stop2_nxt      = stop_bits;
                    frame_len_nxt  = frame_length;
                    bit_idx_nxt    = '0;
                    parity_acc_nxt = 1'b0;
                    stop_idx_nxt   = 1'b0;
                    state_nxt      = st_start;
                end
            end
            st_start: begin
                if (bit_done) begin
                    os_cnt_nxt = '0;
                    state_nxt  = st_data;
                end
            end
            st_data: begin
                if (bit_done) begin
                    os_cnt_nxt     = '0;
                    parity_acc_nxt = parity_acc_ff ^ shift_ff[0];
                    shift_nxt      = shift_ff >> 1;
                    if (bit_idx == frame_len_ff - 4'd1) begin
                        state_nxt = par_en_ff ? st_parity : st_stop;
                    end else begin
                        bit_idx_nxt = bit_idx + 1'b1;
                    end
                end
            end
            st_parity: begin
                if (bit_done) begin
                    os_cnt_nxt = '0;
                    state_nxt  = st_stop;
                end
            end
            st_stop: begin
                if (bit_done) begin
                    os_cnt_nxt = '0;
                    if (stop2_ff && !stop_idx_ff) begin
                        stop_idx_nxt = 1'b1;    // second stop bit
                    end else begin
                        state_nxt = st_idle;
                    end
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase

        // the line level is registered against the state it enters
        case (state_nxt)
            st_start:  tx_nxt = 1'b0;
            st_data:   tx_nxt = shift_nxt[0];
            st_parity: tx_nxt = parity_acc_nxt ^ par_type_ff;
            default:   tx_nxt = 1'b1;
        endcase
    end

    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            os_cnt  <= '0;
            bit_idx <= '0;
            tx_ff   <= 1'b1;
        end else begin
            state   <= state_nxt;
            os_cnt  <= os_cnt_nxt;
            bit_idx <= bit_idx_nxt;
            tx_ff   <= tx_nxt;
        end
    end

    always_ff @(posedge clk_16bd) begin
        shift_ff      <= shift_nxt;
        parity_acc_ff <= parity_acc_nxt;
        stop_idx_ff   <= stop_idx_nxt;
        par_en_ff     <= par_en_nxt;
        par_type_ff   <= par_type_nxt;
        stop2_ff      <= stop2_nxt;
        frame_len_ff  <= frame_len_nxt;
    end

endmodule

//--- uart_tx_assert.sv
`timescale 1ns/100ps

module uart_tx_assert
    import uart_line_pkg::*;
(
    input logic      clk_16bd,
    input logic      rst,
    input tx_state_t state,
    input os_count_t os_cnt,
    input logic      pop,
    input logic      tx
);

    // ********************
    // line and handshake rules
    // ********************
    idle_line_high: assert property (@(posedge clk_16bd) disable iff (rst)
        (state == st_idle) |-> tx)
        else $error("tx is low while the serializer is idle");

    pop_starts_frame: assert property (@(posedge clk_16bd) disable iff (rst)
        pop |=> (state == st_start) && !tx)
        else $error("a pop did not start a frame with a low start bit");

    bit_full_length: assert property (@(posedge clk_16bd) disable iff (rst)
        (state != st_idle) && (os_cnt != os_count_t'(os_rate - 1)) |=> (state == $past(state)))
        else $error("a line bit ended before the oversampling count was reached");

endmodule

bind uart_tx uart_tx_assert u_tx_assert (
    .clk_16bd (clk_16bd),
    .rst      (rst),
    .state    (state),
    .os_cnt   (os_cnt),
    .pop      (pop),
    .tx       (tx)
);

//--- uart_tx_fifo.sv
`timescale 1ns/100ps

module uart_tx_fifo
    import uart_line_pkg::*;
(
    input  logic  clk_16bd,
    input  logic  rst,
    input  logic  push,
    input  byte_t push_data,
    input  logic  pop,
    output byte_t pop_data,
    output logic  full,
    output logic  empty
);

    byte_t       mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        do_push;
    logic        do_pop;

    assign full     = (count == fifo_count_t'(fifo_depth));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];      // head entry, valid while not empty

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge clk_16bd or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two so the pointer wraps
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_16bd) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule
